/* hdl/rv_pkg.sv */
/* Shared RV32I types. Addresses are 16 bits; registers x0..x31 sit at byte address n*4
   of the same memory that holds code and data */
package rv_pkg;

   localparam int ADDR_W = 16;

   // Supported major opcodes only
   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_AUIPC  = 7'b0010111,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_ALU_I  = 7'b0010011,
      OP_ALU_R  = 7'b0110011
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'h0,
      ALU_SLL  = 4'h1,
      ALU_SLT  = 4'h2,
      ALU_SLTU = 4'h3,
      ALU_XOR  = 4'h4,
      ALU_SRL  = 4'h5,
      ALU_OR   = 4'h6,
      ALU_AND  = 4'h7,
      ALU_SUB  = 4'h8,
      ALU_SRA  = 4'hd,
      ALU_EQ   = 4'hf
   } alu_fn_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   // One instruction word, read through whichever format applies
   typedef union packed {
      logic [31:0] word;
      r_fmt_t      r;
      i_fmt_t      i;
      s_fmt_t      s;
      b_fmt_t      b;
      u_fmt_t      u;
      j_fmt_t      j;
   } inst_u;

   typedef struct packed {
      opcode_e     opcode;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  funct3;
      alu_fn_e     alu_fn;
      logic [31:0] imm;
      logic        illegal;
   } dec_t;

   // Mask bit 0 covers wr_data[7:0]
   typedef struct packed {
      logic              rd_en;
      logic              wr_en;
      logic [ADDR_W-1:0] addr;
      logic [31:0]       wr_data;
      logic [3:0]        mask;
   } mem_req_t;

endpackage

/* hdl/rv_decode.sv */
/* Combinational RV32I decoder. Only the nine supported opcodes are accepted;
   funct3/funct7 of accepted opcodes are not checked further */
`timescale 1ns/100ps

module rv_decode (
   input  rv_pkg::inst_u i_inst,
   output rv_pkg::dec_t  o_dec
);

   logic [31:0] imm_i;
   logic [31:0] imm_s;
   logic [31:0] imm_b;
   logic [31:0] imm_u;
   logic [31:0] imm_j;

   assign imm_i = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
   assign imm_s = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
   assign imm_b = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                   i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
   assign imm_u = {i_inst.u.imm, 12'h000};
   assign imm_j = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                   i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

   always_comb begin
      o_dec.opcode  = rv_pkg::opcode_e'(i_inst.r.opcode);
      o_dec.rd      = i_inst.r.rd;
      o_dec.rs1     = i_inst.r.rs1;
      o_dec.rs2     = i_inst.r.rs2;
      o_dec.funct3  = i_inst.r.funct3;
      o_dec.alu_fn  = rv_pkg::ALU_ADD;
      o_dec.imm     = imm_i;
      o_dec.illegal = 1'b0;

      case (i_inst.r.opcode)
         rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: o_dec.imm = imm_u;
         rv_pkg::OP_JAL:                   o_dec.imm = imm_j;
         rv_pkg::OP_JALR, rv_pkg::OP_LOAD: o_dec.imm = imm_i;
         rv_pkg::OP_STORE:                 o_dec.imm = imm_s;
         rv_pkg::OP_BRANCH: begin
            o_dec.imm = imm_b;
            // BEQ/BNE test equality, the rest a signed or unsigned compare
            case (i_inst.r.funct3[2:1])
               2'b10:   o_dec.alu_fn = rv_pkg::ALU_SLT;
               2'b11:   o_dec.alu_fn = rv_pkg::ALU_SLTU;
               default: o_dec.alu_fn = rv_pkg::ALU_EQ;
            endcase
         end
         rv_pkg::OP_ALU_I, rv_pkg::OP_ALU_R: begin
            case (i_inst.r.funct3)
               3'h0: o_dec.alu_fn = (i_inst.r.opcode == rv_pkg::OP_ALU_R && i_inst.r.funct7[5])
                                  ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
               3'h1: o_dec.alu_fn = rv_pkg::ALU_SLL;
               3'h2: o_dec.alu_fn = rv_pkg::ALU_SLT;
               3'h3: o_dec.alu_fn = rv_pkg::ALU_SLTU;
               3'h4: o_dec.alu_fn = rv_pkg::ALU_XOR;
               // imm bit 10 is funct7 bit 5 for shift-immediates
               3'h5: o_dec.alu_fn = i_inst.i.imm[10] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
               3'h6: o_dec.alu_fn = rv_pkg::ALU_OR;
               default: o_dec.alu_fn = rv_pkg::ALU_AND;
            endcase
         end
         default: o_dec.illegal = 1'b1;
      endcase
   end

endmodule

/* hdl/rv_alu.sv */
/* 32-bit integer ALU. Compare functions return 0 or 1 in bit 0,
   which the branch rule below relies on */
`timescale 1ns/100ps

module rv_alu (
   input  logic [31:0]     i_a,
   input  logic [31:0]     i_b,
   input  rv_pkg::alu_fn_e i_fn,
   input  logic [2:0]      i_funct3,
   output logic [31:0]     o_res,
   output logic            o_br_taken
);

   logic [4:0] shamt;

   assign shamt = i_b[4:0];

   always_comb begin
      case (i_fn)
         rv_pkg::ALU_SUB:  o_res = i_a - i_b;
         rv_pkg::ALU_SLL:  o_res = i_a << shamt;
         rv_pkg::ALU_SLT:  o_res = {31'b0, $signed(i_a) < $signed(i_b)};
         rv_pkg::ALU_SLTU: o_res = {31'b0, i_a < i_b};
         rv_pkg::ALU_XOR:  o_res = i_a ^ i_b;
         rv_pkg::ALU_SRL:  o_res = i_a >> shamt;
         rv_pkg::ALU_SRA:  o_res = $unsigned($signed(i_a) >>> shamt);
         rv_pkg::ALU_OR:   o_res = i_a | i_b;
         rv_pkg::ALU_AND:  o_res = i_a & i_b;
         rv_pkg::ALU_EQ:   o_res = {31'b0, i_a == i_b};
         default:          o_res = i_a + i_b;
      endcase
   end

   // funct3 bit 0 inverts the test: BNE, BGE, BGEU
   always_comb begin
      case (i_funct3)
         3'h0, 3'h4, 3'h6: o_br_taken = o_res[0];
         3'h1, 3'h5, 3'h7: o_br_taken = ~o_res[0];
         default:          o_br_taken = 1'b0;
      endcase
   end

endmodule

/* hdl/rv_lsu_align.sv */
/* Byte-lane alignment for loads and stores within one 32-bit word.
   Accesses that cross a word boundary are truncated, not split */
`timescale 1ns/100ps

module rv_lsu_align (
   input  logic [1:0]  i_addr_lo,
   input  logic [2:0]  i_funct3,
   input  logic [31:0] i_rs2_val,
   input  logic [31:0] i_rd_word,
   output logic [31:0] o_st_data,
   output logic [3:0]  o_st_mask,
   output logic [31:0] o_ld_val
);

   logic [4:0]  lane_shift;
   logic [3:0]  base_mask;
   logic [31:0] ld_shifted;

   assign lane_shift = {i_addr_lo, 3'b000};

   // Store: move data up to its byte lane
   always_comb begin
      case (i_funct3[1:0])
         2'b00:   base_mask = 4'b0001;
         2'b01:   base_mask = 4'b0011;
         default: base_mask = 4'b1111;
      endcase
   end

   assign o_st_data = i_rs2_val << lane_shift;
   assign o_st_mask = base_mask << i_addr_lo;

   // Load: bring the addressed lane down to bit 0
   assign ld_shifted = i_rd_word >> lane_shift;

   always_comb begin
      case (i_funct3)
         3'h0:    o_ld_val = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
         3'h1:    o_ld_val = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
         3'h4:    o_ld_val = {24'b0, ld_shifted[7:0]};
         3'h5:    o_ld_val = {16'b0, ld_shifted[15:0]};
         default: o_ld_val = ld_shifted;
      endcase
   end

endmodule

/* hdl/rv_control.sv */
/* Multi-cycle sequencer: boot, fetch, register reads through memory, execute, write back.
   One read outstanding at a time; a write to address 0 is dropped so x0 stays zero */
`timescale 1ns/100ps

module rv_control #(
   parameter logic [rv_pkg::ADDR_W-1:0] VEC_RESET = 16'h0080,
   parameter logic [rv_pkg::ADDR_W-1:0] VEC_SP    = 16'h0084
) (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic [31:0]        i_rd_data,
   input  logic               i_rd_valid,
   input  rv_pkg::dec_t       i_dec,
   input  logic [31:0]        i_alu_res,
   input  logic               i_br_taken,
   input  logic [31:0]        i_st_data,
   input  logic [3:0]         i_st_mask,
   input  logic [31:0]        i_ld_val,
   output rv_pkg::inst_u      o_inst,
   output logic [31:0]        o_alu_a,
   output logic [31:0]        o_alu_b,
   output rv_pkg::alu_fn_e    o_alu_fn,
   output logic [31:0]        o_rs2_val,
   output logic [1:0]         o_addr_lo,
   output logic [2:0]         o_funct3,
   output rv_pkg::mem_req_t   o_mem_req,
   output logic               o_fault
);

   localparam int AW = rv_pkg::ADDR_W;

   typedef enum logic [4:0] {
      S_RESET, S_SP_RD, S_SP_WAIT, S_SP_WR, S_PC_RD, S_PC_WAIT,
      S_FETCH, S_FETCH_WAIT, S_DISPATCH, S_RS1_WAIT, S_RS2_RD, S_RS2_WAIT,
      S_WB, S_BRANCH, S_STORE, S_LOAD_RD, S_LOAD_WAIT, S_LOAD_WR, S_FAULT
   } state_e;

   state_e        state;
   state_e        state_nxt;
   logic [AW-1:0] pc;
   logic [AW-1:0] pc_nxt;
   logic [AW-1:0] pc_plus4;
   logic [AW-1:0] br_target;
   logic [31:0]   pc_ext;
   logic [31:0]   link;
   logic [AW-1:0] rd_addr;
   rv_pkg::inst_u ir;
   logic [31:0]   rs1_val;
   logic [31:0]   rs2_val;
   logic [31:0]   ld_val;

   logic is_lui, is_auipc, is_jal, is_jalr, is_br, is_ld, is_st, is_alu_r;

   assign is_lui   = i_dec.opcode == rv_pkg::OP_LUI;
   assign is_auipc = i_dec.opcode == rv_pkg::OP_AUIPC;
   assign is_jal   = i_dec.opcode == rv_pkg::OP_JAL;
   assign is_jalr  = i_dec.opcode == rv_pkg::OP_JALR;
   assign is_br    = i_dec.opcode == rv_pkg::OP_BRANCH;
   assign is_ld    = i_dec.opcode == rv_pkg::OP_LOAD;
   assign is_st    = i_dec.opcode == rv_pkg::OP_STORE;
   assign is_alu_r = i_dec.opcode == rv_pkg::OP_ALU_R;

   assign pc_plus4  = pc + AW'(4);
   assign br_target = pc + i_dec.imm[AW-1:0];
   assign pc_ext    = {{(32-AW){1'b0}}, pc};
   assign link      = {{(32-AW){1'b0}}, pc_plus4};
   assign rd_addr   = {{(AW-7){1'b0}}, i_dec.rd, 2'b00};

   // Operand select
   always_comb begin
      o_alu_a = rs1_val;
      o_alu_b = i_dec.imm;
      if (is_auipc || is_jal)
         o_alu_a = pc_ext;
      else if (is_lui)
         o_alu_a = '0;
      if (is_alu_r || is_br)
         o_alu_b = rs2_val;
   end

   assign o_alu_fn  = i_dec.alu_fn;
   assign o_inst    = ir;
   assign o_rs2_val = rs2_val;
   assign o_addr_lo = i_alu_res[1:0];
   assign o_funct3  = i_dec.funct3;
   assign o_fault   = state == S_FAULT;

   always_comb begin
      state_nxt = state;
      pc_nxt    = pc;
      o_mem_req = '0;
      o_mem_req.mask = 4'b1111;

      case (state)
         S_RESET: state_nxt = S_SP_RD;
         S_SP_RD: begin
            o_mem_req.rd_en = 1'b1;
            o_mem_req.addr  = VEC_SP;
            state_nxt       = S_SP_WAIT;
         end
         S_SP_WAIT: if (i_rd_valid) state_nxt = S_SP_WR;
         S_SP_WR: begin
            // x2 is the stack pointer
            o_mem_req.wr_en   = 1'b1;
            o_mem_req.addr    = AW'(8);
            o_mem_req.wr_data = ld_val;
            state_nxt         = S_PC_RD;
         end
         S_PC_RD: begin
            o_mem_req.rd_en = 1'b1;
            o_mem_req.addr  = VEC_RESET;
            state_nxt       = S_PC_WAIT;
         end
         S_PC_WAIT: begin
            if (i_rd_valid) begin
               pc_nxt    = i_rd_data[AW-1:0];
               state_nxt = S_FETCH;
            end
         end
         S_FETCH: begin
            o_mem_req.rd_en = 1'b1;
            o_mem_req.addr  = pc;
            state_nxt       = S_FETCH_WAIT;
         end
         S_FETCH_WAIT: if (i_rd_valid) state_nxt = S_DISPATCH;
         S_DISPATCH: begin
            if (i_dec.illegal) begin
               state_nxt = S_FAULT;
            end else if (is_lui || is_auipc || is_jal) begin
               o_mem_req.wr_en   = 1'b1;
               o_mem_req.addr    = rd_addr;
               o_mem_req.wr_data = is_jal ? link : i_alu_res;
               pc_nxt            = is_jal ? i_alu_res[AW-1:0] : pc_plus4;
               state_nxt         = S_FETCH;
            end else begin
               o_mem_req.rd_en = 1'b1;
               o_mem_req.addr  = {{(AW-7){1'b0}}, i_dec.rs1, 2'b00};
               state_nxt       = S_RS1_WAIT;
            end
         end
         S_RS1_WAIT: begin
            if (i_rd_valid) begin
               if (is_alu_r || is_br || is_st)
                  state_nxt = S_RS2_RD;
               else if (is_ld)
                  state_nxt = S_LOAD_RD;
               else
                  state_nxt = S_WB;
            end
         end
         S_RS2_RD: begin
            o_mem_req.rd_en = 1'b1;
            o_mem_req.addr  = {{(AW-7){1'b0}}, i_dec.rs2, 2'b00};
            state_nxt       = S_RS2_WAIT;
         end
         S_RS2_WAIT: begin
            if (i_rd_valid)
               state_nxt = is_br ? S_BRANCH : (is_st ? S_STORE : S_WB);
         end
         S_WB: begin
            o_mem_req.wr_en   = 1'b1;
            o_mem_req.addr    = rd_addr;
            o_mem_req.wr_data = is_jalr ? link : i_alu_res;
            pc_nxt    = is_jalr ? {i_alu_res[AW-1:1], 1'b0} : pc_plus4;
            state_nxt = S_FETCH;
         end
         S_BRANCH: begin
            pc_nxt    = i_br_taken ? br_target : pc_plus4;
            state_nxt = S_FETCH;
         end
         S_STORE: begin
            o_mem_req.wr_en   = 1'b1;
            o_mem_req.addr    = i_alu_res[AW-1:0];
            o_mem_req.wr_data = i_st_data;
            o_mem_req.mask    = i_st_mask;
            pc_nxt            = pc_plus4;
            state_nxt         = S_FETCH;
         end
         S_LOAD_RD: begin
            o_mem_req.rd_en = 1'b1;
            o_mem_req.addr  = i_alu_res[AW-1:0];
            state_nxt       = S_LOAD_WAIT;
         end
         S_LOAD_WAIT: if (i_rd_valid) state_nxt = S_LOAD_WR;
         S_LOAD_WR: begin
            o_mem_req.wr_en   = 1'b1;
            o_mem_req.addr    = rd_addr;
            o_mem_req.wr_data = ld_val;
            pc_nxt            = pc_plus4;
            state_nxt         = S_FETCH;
         end
         default: state_nxt = S_FAULT;
      endcase

      // Address 0 is x0
      if (o_mem_req.addr == '0)
         o_mem_req.wr_en = 1'b0;
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= S_RESET;
         pc    <= '0;
      end else begin
         state <= state_nxt;
         pc    <= pc_nxt;
      end
   end

   // Payload captures on read return
   always_ff @(posedge clk) begin
      if (i_rd_valid) begin
         case (state)
            S_SP_WAIT:    ld_val  <= i_rd_data;
            S_FETCH_WAIT: ir      <= i_rd_data;
            S_RS1_WAIT:   rs1_val <= i_rd_data;
            S_RS2_WAIT:   rs2_val <= i_rd_data;
            S_LOAD_WAIT:  ld_val  <= i_ld_val;
            default:      ;
         endcase
      end
   end

endmodule

/* hdl/rv_core.sv */
/* RV32I multi-cycle core top. Register file lives in memory at 0x00..0x7f;
   boot reads the SP and reset vectors from the given addresses */
`timescale 1ns/100ps

module rv_core #(
   parameter logic [rv_pkg::ADDR_W-1:0] VEC_RESET = 16'h0080,
   parameter logic [rv_pkg::ADDR_W-1:0] VEC_SP    = 16'h0084
) (
   input  logic             clk,
   input  logic             i_arst_n,
   input  logic [31:0]      i_rd_data,
   input  logic             i_rd_valid,
   output rv_pkg::mem_req_t o_mem_req,
   output logic             o_fault
);

   rv_pkg::inst_u   inst;
   rv_pkg::dec_t    dec;
   rv_pkg::alu_fn_e alu_fn;
   logic [31:0]     alu_a;
   logic [31:0]     alu_b;
   logic [31:0]     alu_res;
   logic            br_taken;
   logic [31:0]     rs2_val;
   logic [1:0]      addr_lo;
   logic [2:0]      funct3;
   logic [31:0]     st_data;
   logic [3:0]      st_mask;
   logic [31:0]     ld_val;

   rv_control #(
      .VEC_RESET (VEC_RESET),
      .VEC_SP    (VEC_SP)
   ) rv_control_inst (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_rd_data  (i_rd_data),
      .i_rd_valid (i_rd_valid),
      .i_dec      (dec),
      .i_alu_res  (alu_res),
      .i_br_taken (br_taken),
      .i_st_data  (st_data),
      .i_st_mask  (st_mask),
      .i_ld_val   (ld_val),
      .o_inst     (inst),
      .o_alu_a    (alu_a),
      .o_alu_b    (alu_b),
      .o_alu_fn   (alu_fn),
      .o_rs2_val  (rs2_val),
      .o_addr_lo  (addr_lo),
      .o_funct3   (funct3),
      .o_mem_req  (o_mem_req),
      .o_fault    (o_fault)
   );

   rv_decode rv_decode_inst (
      .i_inst (inst),
      .o_dec  (dec)
   );

   rv_alu rv_alu_inst (
      .i_a        (alu_a),
      .i_b        (alu_b),
      .i_fn       (alu_fn),
      .i_funct3   (funct3),
      .o_res      (alu_res),
      .o_br_taken (br_taken)
   );

   // Load word comes straight from the memory port
   rv_lsu_align rv_lsu_align_inst (
      .i_addr_lo (addr_lo),
      .i_funct3  (funct3),
      .i_rs2_val (rs2_val),
      .i_rd_word (i_rd_data),
      .o_st_data (st_data),
      .o_st_mask (st_mask),
      .o_ld_val  (ld_val)
   );

endmodule

/* verif/rv_core_tb.sv */
/* Testbench for rv_core. Each table entry boots the core from reset and runs one
   instruction at 0x0100; registers other than x0 and x2 start from table values */
`timescale 1ns/100ps

module rv_core_tb;

   localparam logic [15:0] VEC_RESET = 16'h0080;
   localparam logic [15:0] VEC_SP    = 16'h0084;
   localparam logic [15:0] PC0       = 16'h0100;
   localparam logic [31:0] SP_WORD   = 32'h0000_fff0;
   localparam int          WAIT_MAX  = 40;
   localparam int          QUIET_CYC = 20;

   typedef struct packed {
      rv_pkg::inst_u inst;
      logic [31:0]   v1;
      logic [31:0]   v2;
      logic [31:0]   pre;
   } entry_t;

   // Expected bus activity of one instruction
   typedef struct packed {
      logic             fault;
      logic [1:0]       n_rd;
      logic [15:0]      rd_a0;
      logic [15:0]      rd_a1;
      logic             has_wr;
      rv_pkg::mem_req_t wr;
      logic [15:0]      next_pc;
   } exp_t;

   logic             clk;
   logic             i_arst_n;
   logic [31:0]      i_rd_data;
   logic             i_rd_valid;
   rv_pkg::mem_req_t o_mem_req;
   logic             o_fault;

   logic [7:0]  mem [0:65535];
   logic [31:0] rng = 32'd39946;
   int          pend_cnt;
   logic [15:0] pend_addr;
   entry_t      tbl[$];

   rv_core #(
      .VEC_RESET (VEC_RESET),
      .VEC_SP    (VEC_SP)
   ) rv_core_inst (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_rd_data  (i_rd_data),
      .i_rd_valid (i_rd_valid),
      .o_mem_req  (o_mem_req),
      .o_fault    (o_fault)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rng;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng = x;
      return x;
   endfunction

   function automatic logic [31:0] read_word(logic [15:0] addr);
      logic [15:0] a;
      a = {addr[15:2], 2'b00};
      return {mem[a + 16'd3], mem[a + 16'd2], mem[a + 16'd1], mem[a]};
   endfunction

   task automatic write_word(logic [15:0] addr, logic [31:0] data);
      for (int b = 0; b < 4; b++)
         mem[{addr[15:2], 2'b00} + 16'(b)] = data[8*b +: 8];
   endtask

   function automatic logic [15:0] reg_addr(logic [4:0] idx);
      return {9'b0, idx, 2'b00};
   endfunction

   // x2 is overwritten by the boot sequence
   function automatic logic [31:0] reg_val(logic [4:0] idx);
      if (idx == 5'd0)
         return 32'h0;
      if (idx == 5'd2)
         return SP_WORD;
      return read_word(reg_addr(idx));
   endfunction

   task automatic fail(string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
         fail($sformatf("CHECK FAILED %s got 0x%h exp 0x%h", name, got, exp));
   endtask

   task automatic check_req(rv_pkg::mem_req_t got, rv_pkg::mem_req_t exp);
      if (got !== exp)
         fail($sformatf("CHECK FAILED o_mem_req got 0x%h exp 0x%h", got, exp));
   endtask

   task automatic check_fault(logic exp);
      if (o_fault !== exp)
         fail($sformatf("CHECK FAILED o_fault got 0x%h exp 0x%h", o_fault, exp));
   endtask

   // Memory model clock that returns the request seen in this cycle
   task automatic tick(output rv_pkg::mem_req_t req);
      @(posedge clk);
      #1;
      req = o_mem_req;
      i_rd_valid = 1'b0;
      if (pend_cnt > 0) begin
         pend_cnt--;
         if (pend_cnt == 0) begin
            i_rd_valid = 1'b1;
            i_rd_data  = read_word(pend_addr);
         end
      end
      if (req.wr_en) begin
         for (int b = 0; b < 4; b++)
            if (req.mask[b])
               mem[{req.addr[15:2], 2'b00} + 16'(b)] = req.wr_data[8*b +: 8];
      end
      if (req.rd_en) begin
         pend_addr = req.addr;
         pend_cnt  = 1 + int'(xorshift() % 32'd3);
      end
   endtask

   task automatic next_event(output rv_pkg::mem_req_t req);
      for (int n = 0; n < WAIT_MAX; n++) begin
         tick(req);
         if (req.rd_en || req.wr_en)
            return;
      end
      fail($sformatf("No memory request from the core within %0d cycles", WAIT_MAX));
   endtask

   task automatic expect_read(string what, logic [15:0] addr);
      rv_pkg::mem_req_t req;
      next_event(req);
      if (!req.rd_en)
         fail({"Core wrote memory where a read of the ", what, " was due"});
      check_word(what, 32'(req.addr), 32'(addr));
   endtask

   task automatic expect_write(rv_pkg::mem_req_t exp);
      rv_pkg::mem_req_t req;
      next_event(req);
      if (!req.wr_en)
         fail("Core read memory where a write was due");
      check_req(req, exp);
   endtask

   task automatic watch_fault();
      rv_pkg::mem_req_t req;
      int n;
      n = 0;
      while (!o_fault && n < WAIT_MAX) begin
         tick(req);
         n++;
      end
      check_fault(1'b1);
      for (int k = 0; k < QUIET_CYC; k++) begin
         tick(req);
         if (req.rd_en || req.wr_en)
            fail("Core kept using the memory port after the fault");
      end
   endtask

   task automatic apply_reset();
      i_arst_n   = 1'b0;
      i_rd_valid = 1'b0;
      pend_cnt   = 0;
      repeat (2) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
   endtask

   function automatic logic [31:0] alu_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
      logic [31:0] r;
      logic [4:0]  sh;
      sh = b[4:0];
      case (f3)
         3'd0: r = alt ? a - b : a + b;
         3'd1: r = a << sh;
         3'd2: r = {31'b0, $signed(a) < $signed(b)};
         3'd3: r = {31'b0, a < b};
         3'd4: r = a ^ b;
         3'd5: begin
            if (alt)
               r = $signed(a) >>> sh;
            else
               r = a >> sh;
         end
         3'd6: r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   // Reference model of RV32I behavior on raw instruction bits
   function automatic exp_t ref_model(rv_pkg::inst_u in, logic [31:0] r1, logic [31:0] r2,
                                      logic [31:0] pre);
      exp_t        e;
      logic [31:0] w;
      logic [31:0] ii;
      logic [31:0] si;
      logic [31:0] bi;
      logic [31:0] ji;
      logic [31:0] ea;
      logic [31:0] lw;
      logic [15:0] pc4;
      logic [2:0]  f3;
      logic [1:0]  off;
      logic        take;
      w   = in.word;
      f3  = w[14:12];
      pc4 = PC0 + 16'd4;
      ii  = {{20{w[31]}}, w[31:20]};
      si  = {{20{w[31]}}, w[31:25], w[11:7]};
      bi  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      ji  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      e = '0;
      e.next_pc    = pc4;
      e.wr.wr_en   = 1'b1;
      e.wr.mask    = 4'hf;
      e.wr.addr    = reg_addr(w[11:7]);
      e.has_wr     = w[11:7] != 5'd0;
      e.rd_a0      = reg_addr(w[19:15]);
      e.rd_a1      = reg_addr(w[24:20]);
      case (w[6:0])
         rv_pkg::OP_LUI:   e.wr.wr_data = {w[31:12], 12'b0};
         rv_pkg::OP_AUIPC: e.wr.wr_data = {16'b0, PC0} + {w[31:12], 12'b0};
         rv_pkg::OP_JAL: begin
            e.wr.wr_data = {16'b0, pc4};
            e.next_pc    = PC0 + ji[15:0];
         end
         rv_pkg::OP_JALR: begin
            e.n_rd       = 2'd1;
            ea           = r1 + ii;
            e.wr.wr_data = {16'b0, pc4};
            e.next_pc    = {ea[15:1], 1'b0};
         end
         rv_pkg::OP_BRANCH: begin
            e.n_rd   = 2'd2;
            e.has_wr = 1'b0;
            case (f3)
               3'd0: take = r1 == r2;
               3'd1: take = r1 != r2;
               3'd4: take = $signed(r1) < $signed(r2);
               3'd5: take = $signed(r1) >= $signed(r2);
               3'd6: take = r1 < r2;
               3'd7: take = r1 >= r2;
               default: take = 1'b0;
            endcase
            e.next_pc = take ? PC0 + bi[15:0] : pc4;
         end
         rv_pkg::OP_LOAD: begin
            e.n_rd  = 2'd2;
            ea      = r1 + ii;
            e.rd_a1 = ea[15:0];
            off     = ea[1:0];
            lw      = pre >> {off, 3'b000};
            case (f3)
               3'd0: e.wr.wr_data = {{24{lw[7]}}, lw[7:0]};
               3'd1: e.wr.wr_data = {{16{lw[15]}}, lw[15:0]};
               3'd4: e.wr.wr_data = {24'b0, lw[7:0]};
               3'd5: e.wr.wr_data = {16'b0, lw[15:0]};
               default: e.wr.wr_data = lw;
            endcase
         end
         rv_pkg::OP_STORE: begin
            e.n_rd       = 2'd2;
            ea           = r1 + si;
            off          = ea[1:0];
            e.has_wr     = ea[15:0] != 16'h0;
            e.wr.addr    = ea[15:0];
            e.wr.wr_data = r2 << {off, 3'b000};
            e.wr.mask    = (f3 == 3'd0 ? 4'b0001 : (f3 == 3'd1 ? 4'b0011 : 4'b1111)) << off;
         end
         rv_pkg::OP_ALU_I: begin
            e.n_rd       = 2'd1;
            e.wr.wr_data = alu_op(f3, w[30] && f3 == 3'd5, r1, ii);
         end
         rv_pkg::OP_ALU_R: begin
            e.n_rd       = 2'd2;
            e.wr.wr_data = alu_op(f3, w[30], r1, r2);
         end
         default: begin
            e.fault  = 1'b1;
            e.has_wr = 1'b0;
         end
      endcase
      return e;
   endfunction

   function automatic rv_pkg::inst_u enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
      rv_pkg::inst_u x;
      x.r.funct7 = f7;
      x.r.rs2    = rs2;
      x.r.rs1    = rs1;
      x.r.funct3 = f3;
      x.r.rd     = rd;
      x.r.opcode = op;
      return x;
   endfunction

   function automatic rv_pkg::inst_u enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
      rv_pkg::inst_u x;
      x.i.imm    = imm;
      x.i.rs1    = rs1;
      x.i.funct3 = f3;
      x.i.rd     = rd;
      x.i.opcode = op;
      return x;
   endfunction

   function automatic rv_pkg::inst_u enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
      rv_pkg::inst_u x;
      x.s.imm_hi = imm[11:5];
      x.s.rs2    = rs2;
      x.s.rs1    = rs1;
      x.s.funct3 = f3;
      x.s.imm_lo = imm[4:0];
      x.s.opcode = rv_pkg::OP_STORE;
      return x;
   endfunction

   function automatic rv_pkg::inst_u enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
      rv_pkg::inst_u x;
      x.b.imm_12   = imm[12];
      x.b.imm_10_5 = imm[10:5];
      x.b.rs2      = rs2;
      x.b.rs1      = rs1;
      x.b.funct3   = f3;
      x.b.imm_4_1  = imm[4:1];
      x.b.imm_11   = imm[11];
      x.b.opcode   = rv_pkg::OP_BRANCH;
      return x;
   endfunction

   function automatic rv_pkg::inst_u enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
      rv_pkg::inst_u x;
      x.u.imm    = imm;
      x.u.rd     = rd;
      x.u.opcode = op;
      return x;
   endfunction

   function automatic rv_pkg::inst_u enc_j(logic [20:0] imm, logic [4:0] rd);
      rv_pkg::inst_u x;
      x.j.imm_20    = imm[20];
      x.j.imm_10_1  = imm[10:1];
      x.j.imm_11    = imm[11];
      x.j.imm_19_12 = imm[19:12];
      x.j.rd        = rd;
      x.j.opcode    = rv_pkg::OP_JAL;
      return x;
   endfunction

   task automatic add(rv_pkg::inst_u inst, logic [31:0] v1, logic [31:0] v2, logic [31:0] pre);
      entry_t t;
      t.inst = inst;
      t.v1   = v1;
      t.v2   = v2;
      t.pre  = pre;
      tbl.push_back(t);
   endtask

   task automatic build_table();
      int          br_f3 [6] = '{0, 1, 4, 5, 6, 7};
      int          ld_f3 [5] = '{0, 1, 2, 4, 5};
      logic [31:0] r;
      logic [31:0] v;
      for (int f = 0; f < 8; f++)
         add(enc_r(7'h00, 5'd7, 5'd6, 3'(f), 5'd5, rv_pkg::OP_ALU_R), xorshift(), xorshift(), 0);
      add(enc_r(7'h20, 5'd7, 5'd6, 3'd0, 5'd5, rv_pkg::OP_ALU_R), xorshift(), xorshift(), 0);
      add(enc_r(7'h20, 5'd7, 5'd6, 3'd5, 5'd5, rv_pkg::OP_ALU_R), xorshift(), xorshift(), 0);
      for (int f = 0; f < 8; f++) begin
         r = xorshift();
         if (f == 1 || f == 5)
            r = {27'b0, r[4:0]};
         add(enc_i(r[11:0], 5'd6, 3'(f), 5'd5, rv_pkg::OP_ALU_I), xorshift(), 0, 0);
      end
      r = xorshift();
      add(enc_i({7'h20, r[4:0]}, 5'd6, 3'd5, 5'd5, rv_pkg::OP_ALU_I), xorshift(), 0, 0);
      // rd = x0 must leave the bus quiet after the operand read
      add(enc_i(12'h123, 5'd6, 3'd0, 5'd0, rv_pkg::OP_ALU_I), xorshift(), 0, 0);
      r = xorshift();
      add(enc_u(r[19:0], 5'd9, rv_pkg::OP_LUI), 0, 0, 0);
      r = xorshift();
      add(enc_u(r[19:0], 5'd9, rv_pkg::OP_AUIPC), 0, 0, 0);
      foreach (br_f3[k]) begin
         v = xorshift();
         add(enc_b(13'h0010, 5'd7, 5'd6, 3'(br_f3[k])), v, v, 0);
         add(enc_b(13'h1ff8, 5'd7, 5'd6, 3'(br_f3[k])), xorshift(), xorshift(), 0);
         add(enc_b(13'h0010, 5'd7, 5'd6, 3'(br_f3[k])), 32'hffff_fff0, 32'h0000_0010, 0);
         add(enc_b(13'h0010, 5'd7, 5'd6, 3'(br_f3[k])), 32'h0000_0010, 32'hffff_fff0, 0);
      end
      add(enc_j(21'h000040, 5'd1), 0, 0, 0);
      add(enc_i(12'h005, 5'd6, 3'd0, 5'd1, rv_pkg::OP_JALR), 32'h0000_0300, 0, 0);
      for (int f = 0; f < 3; f++)
         for (int off = 0; off < 4; off += (1 << f))
            add(enc_s(12'(off), 5'd7, 5'd6, 3'(f)), 32'h0000_0400, xorshift(), 0);
      foreach (ld_f3[k])
         for (int off = 0; off < 4; off += (1 << (ld_f3[k] % 4)))
            add(enc_i(12'(off), 5'd6, 3'(ld_f3[k]), 5'd8, rv_pkg::OP_LOAD),
                32'h0000_0500, 0, xorshift());
      add(rv_pkg::inst_u'(32'h0000_007f), 0, 0, 0);
   endtask

   task automatic run_entry(entry_t t);
      exp_t             e;
      rv_pkg::mem_req_t boot_wr;
      logic [31:0]      r1;
      logic [31:0]      r2;
      logic [15:0]      a16;
      for (int a = 0; a < 65536; a++) begin
         a16    = 16'(a);
         mem[a] = a16[15:8] ^ a16[7:0] ^ 8'h5a;
      end
      write_word(16'h0000, 32'h0);
      write_word(VEC_SP, SP_WORD);
      write_word(VEC_RESET, {16'b0, PC0});
      write_word(PC0, t.inst.word);
      if (t.inst.r.rs1 != 5'd0)
         write_word(reg_addr(t.inst.r.rs1), t.v1);
      if (t.inst.r.rs2 != 5'd0)
         write_word(reg_addr(t.inst.r.rs2), t.v2);
      r1 = reg_val(t.inst.r.rs1);
      r2 = reg_val(t.inst.r.rs2);
      e  = ref_model(t.inst, r1, r2, t.pre);
      if (t.inst.r.opcode == rv_pkg::OP_LOAD)
         write_word(e.rd_a1, t.pre);

      apply_reset();
      boot_wr         = '0;
      boot_wr.wr_en   = 1'b1;
      boot_wr.addr    = 16'h0008;
      boot_wr.wr_data = SP_WORD;
      boot_wr.mask    = 4'hf;
      expect_read("sp vector addr", VEC_SP);
      expect_write(boot_wr);
      expect_read("reset vector addr", VEC_RESET);
      expect_read("fetch addr", PC0);
      if (e.fault) begin
         watch_fault();
      end else begin
         if (e.n_rd > 2'd0)
            expect_read("rs1 addr", e.rd_a0);
         if (e.n_rd > 2'd1)
            expect_read("second read addr", e.rd_a1);
         if (e.has_wr)
            expect_write(e.wr);
         expect_read("next fetch addr", e.next_pc);
         check_fault(1'b0);
      end
   endtask

   initial begin
      i_arst_n   = 1'b0;
      i_rd_valid = 1'b0;
      i_rd_data  = 32'h0;
      pend_cnt   = 0;
      pend_addr  = 16'h0;
      build_table();
      foreach (tbl[k])
         run_entry(tbl[k]);
      $display("TB PASSED");
      $finish;
   end

endmodule

/* sources.f */
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_lsu_align.sv
hdl/rv_control.sv
hdl/rv_core.sv
verif/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TB PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) hdl/*.sv verif/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
